//--- common/rf_defs.svh
`ifndef RF_DEFS_SVH
`define RF_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// Register file sizing

// Physical registers, register 0 hardwired to zero
`define RF_NUM_PHYS_REGS 64

// Source operand ports
`define RF_READ_PORTS 2

//////////////////////////////////////////////////////////////////////
// Write-back

// Group 0 is the ALU, group 1 the multiplier
`define RF_NUM_WB_GROUPS 2

// Issue cycle to commit cycle for group 1
`define RF_MUL_LATENCY 3

`endif

//--- common/rf_types_pkg.sv
`include "rf_defs.svh"

package rf_types_pkg;

    //////////////////////////////////////////////////////////////////////
    // Data path widths

    // Physical register index
    typedef logic [$clog2(`RF_NUM_PHYS_REGS)-1:0] phys_addr_t;

    // Register contents
    typedef logic [31:0] data_t;

    // LOADI immediate, zero-extended on use
    typedef logic [15:0] imm_t;

    // Write-back group id
    // 0 for the ALU, 1 for the multiplier
    typedef logic [$clog2(`RF_NUM_WB_GROUPS)-1:0] wb_group_t;

    //////////////////////////////////////////////////////////////////////
    // Issue control

    // Wait for the in-use sweep, then issue
    typedef enum logic {
        INIT,
        RUN
    } issue_state_t;

endpackage

//--- common/rf_pipe_pkg.sv
package rf_pipe_pkg;

    //////////////////////////////////////////////////////////////////////
    // Instruction format

    // MUL goes to group 1, all others to the ALU
    typedef enum logic [1:0] {
        LOADI = 2'd0,
        ADD   = 2'd1,
        XOR   = 2'd2,
        MUL   = 2'd3
    } op_t;

    // 36 bits in total
    typedef struct packed {
        op_t                      op;
        rf_types_pkg::phys_addr_t rd;
        rf_types_pkg::phys_addr_t rs1;
        rf_types_pkg::phys_addr_t rs2;
        rf_types_pkg::imm_t       imm;
    } inst_t;

    //////////////////////////////////////////////////////////////////////
    // Write-back

    // One per group, writes the bank at the next edge
    // 39 bits in total
    typedef struct packed {
        logic                     valid;
        rf_types_pkg::phys_addr_t phys_addr;
        rf_types_pkg::data_t      data;
    } commit_t;

endpackage

//--- design/issue_ctrl.sv
`include "rf_defs.svh"

module issue_ctrl (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      inst_valid,
    input  rf_pipe_pkg::inst_t        inst,
    input  logic                      init_done,
    input  logic                      rs_inuse [`RF_READ_PORTS],
    input  logic                      rd_inuse,
    output logic                      ready,
    output logic                      stall,
    output logic                      issue_alu,
    output logic                      issue_mul,
    output rf_types_pkg::phys_addr_t  rs_addr [`RF_READ_PORTS],
    output rf_types_pkg::phys_addr_t  rd_addr,
    output rf_types_pkg::wb_group_t   rs_group [`RF_READ_PORTS],
    output rf_types_pkg::wb_group_t   rd_group,
    output logic                      set_inuse
);
    rf_types_pkg::issue_state_t state;
    rf_types_pkg::wb_group_t    group_table [`RF_NUM_PHYS_REGS];
    logic                       reads_rs;
    logic                       hazard;
    logic                       issue;

    //////////////////////////////////////////////////////////////////////
    // Start-up
    // Held in INIT while the in-use memory is swept clear
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= rf_types_pkg::INIT;
        end else if (state == rf_types_pkg::INIT && init_done) begin
            state <= rf_types_pkg::RUN;
        end
    end

    assign ready = (state == rf_types_pkg::RUN);

    //////////////////////////////////////////////////////////////////////
    // Hazard check

    // LOADI has no sources
    assign reads_rs = (inst.op != rf_pipe_pkg::LOADI);
    // Pending source, or a pending write to the same rd
    assign hazard = (reads_rs && (rs_inuse[0] || rs_inuse[1])) || rd_inuse;
    // Only meaningful once the sweep is done
    assign stall = inst_valid && ready && hazard;

    assign issue = inst_valid && ready && !stall;
    assign issue_mul = issue && (inst.op == rf_pipe_pkg::MUL);
    assign issue_alu = issue && (inst.op != rf_pipe_pkg::MUL);

    // Register 0 never goes pending
    assign set_inuse = issue_mul && (inst.rd != '0);

    //////////////////////////////////////////////////////////////////////
    // Register addressing and group table
    assign rs_addr[0] = inst.rs1;
    assign rs_addr[1] = inst.rs2;
    assign rd_addr = inst.rd;

    assign rd_group = (inst.op == rf_pipe_pkg::MUL) ? 1'b1 : 1'b0;

    // Bank that last wrote each register
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < `RF_NUM_PHYS_REGS; r++) begin
                group_table[r] <= '0;
            end
        end else if (issue) begin
            group_table[inst.rd] <= rd_group;
        end
    end

    always_comb begin
        for (int i = 0; i < `RF_READ_PORTS; i++) begin
            rs_group[i] = group_table[rs_addr[i]];
        end
    end

endmodule

//--- register_file/register_bank.sv
`include "rf_defs.svh"

module register_bank (
    input  logic                      clk,
    input  rf_types_pkg::phys_addr_t  write_addr,
    input  rf_types_pkg::data_t       new_data,
    input  logic                      commit,
    input  rf_types_pkg::phys_addr_t  read_addr [`RF_READ_PORTS],
    output rf_types_pkg::data_t       data [`RF_READ_PORTS]
);
    // Distributed RAM, one write port
    rf_types_pkg::data_t storage [`RF_NUM_PHYS_REGS];

    //////////////////////////////////////////////////////////////////////
    // Write port
    always_ff @(posedge clk) begin
        if (commit) begin
            storage[write_addr] <= new_data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read ports
    // Asynchronous, value written at an edge visible right after it
    always_comb begin
        for (int i = 0; i < `RF_READ_PORTS; i++) begin
            data[i] = storage[read_addr[i]];
        end
    end

endmodule

//--- register_file/inuse_toggle_mem.sv
`include "rf_defs.svh"

module inuse_toggle_mem (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      toggle [2],
    input  rf_types_pkg::phys_addr_t  toggle_addr [2],
    input  rf_types_pkg::phys_addr_t  read_addr [3],
    output logic                      in_use [3],
    output logic                      init_done
);
    localparam rf_types_pkg::phys_addr_t LAST_ADDR =
        rf_types_pkg::phys_addr_t'(`RF_NUM_PHYS_REGS - 1);

    // One bit memory per write port
    logic                     toggle_bits [2][`RF_NUM_PHYS_REGS];
    logic                     clearing;
    rf_types_pkg::phys_addr_t clear_addr;

    //////////////////////////////////////////////////////////////////////
    // Clear sweep
    // One entry per cycle from the first cycle after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            clearing <= 1'b1;
            clear_addr <= '0;
        end else if (clearing) begin
            clear_addr <= clear_addr + 1'b1;
            if (clear_addr == LAST_ADDR) begin
                clearing <= 1'b0;
            end
        end
    end

    // High from the last sweep cycle on
    assign init_done = !clearing || (clear_addr == LAST_ADDR);

    //////////////////////////////////////////////////////////////////////
    // Toggle writes
    // Each port flips its own copy, sweep overrides both
    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++) begin
            if (clearing) begin
                toggle_bits[p][clear_addr] <= 1'b0;
            end else if (toggle[p]) begin
                toggle_bits[p][toggle_addr[p]] <= !toggle_bits[p][toggle_addr[p]];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reads
    // Pending when the two copies differ
    always_comb begin
        for (int r = 0; r < 3; r++) begin
            in_use[r] = toggle_bits[0][read_addr[r]] ^ toggle_bits[1][read_addr[r]];
        end
    end

endmodule

//--- register_file/register_file.sv
`include "rf_defs.svh"

module register_file (
    input  logic                      clk,
    input  logic                      reset,
    input  rf_types_pkg::phys_addr_t  rs_addr [`RF_READ_PORTS],
    input  rf_types_pkg::wb_group_t   rs_group [`RF_READ_PORTS],
    input  rf_types_pkg::phys_addr_t  rd_addr,
    input  logic                      set_inuse,
    input  rf_pipe_pkg::commit_t      commit_alu,
    input  rf_pipe_pkg::commit_t      commit_mul,
    output rf_types_pkg::data_t       rs_data [`RF_READ_PORTS],
    output logic                      rs_inuse [`RF_READ_PORTS],
    output logic                      rd_inuse,
    output logic                      init_done
);
    rf_pipe_pkg::commit_t     wb_commit [`RF_NUM_WB_GROUPS];
    rf_types_pkg::data_t      bank_data [`RF_NUM_WB_GROUPS][`RF_READ_PORTS];
    logic                     toggle [2];
    rf_types_pkg::phys_addr_t toggle_addr [2];
    rf_types_pkg::phys_addr_t inuse_addr [3];
    logic                     toggle_inuse [3];

    assign wb_commit[0] = commit_alu;
    assign wb_commit[1] = commit_mul;

    //////////////////////////////////////////////////////////////////////
    // Banks, one per write-back group
    for (genvar g = 0; g < `RF_NUM_WB_GROUPS; g++) begin : g_bank
        register_bank u_register_bank (
            .clk        (clk),
            .write_addr (wb_commit[g].phys_addr),
            .new_data   (wb_commit[g].data),
            .commit     (wb_commit[g].valid),
            .read_addr  (rs_addr),
            .data       (bank_data[g])
        );
    end

    //////////////////////////////////////////////////////////////////////
    // In-use marks for group 1
    // Port 0 sets on MUL issue, port 1 clears on MUL commit
    assign toggle[0] = set_inuse;
    assign toggle_addr[0] = rd_addr;
    assign toggle[1] = commit_mul.valid;
    assign toggle_addr[1] = commit_mul.phys_addr;

    // Both sources plus rd
    assign inuse_addr[0] = rs_addr[0];
    assign inuse_addr[1] = rs_addr[1];
    assign inuse_addr[2] = rd_addr;

    inuse_toggle_mem u_inuse_toggle_mem (
        .clk         (clk),
        .reset       (reset),
        .toggle      (toggle),
        .toggle_addr (toggle_addr),
        .read_addr   (inuse_addr),
        .in_use      (toggle_inuse),
        .init_done   (init_done)
    );

    // A write to rd from group 0 is never pending, so the raw bit serves
    assign rd_inuse = toggle_inuse[2];

    //////////////////////////////////////////////////////////////////////
    // Read muxing by group
    always_comb begin
        for (int i = 0; i < `RF_READ_PORTS; i++) begin
            // Register 0 reads as zero whatever the bank holds
            if (rs_addr[i] == '0) begin
                rs_data[i] = '0;
            end else begin
                rs_data[i] = bank_data[rs_group[i]][i];
            end
            // ALU group commits at issue, never pending
            rs_inuse[i] = (rs_group[i] == 1'b1) && toggle_inuse[i] && (rs_addr[i] != '0);
        end
    end

endmodule

//--- design/alu_unit.sv
`include "rf_defs.svh"

module alu_unit (
    input  logic                  issue,
    input  rf_pipe_pkg::inst_t    inst,
    input  rf_types_pkg::data_t   rs_data [`RF_READ_PORTS],
    output rf_pipe_pkg::commit_t  commit
);
    rf_types_pkg::data_t result;

    // Single cycle, result commits in the issue cycle
    always_comb begin
        case (inst.op)
            // Zero-extend the immediate
            rf_pipe_pkg::LOADI: result = {16'h0000, inst.imm};
            rf_pipe_pkg::ADD:   result = rs_data[0] + rs_data[1];
            rf_pipe_pkg::XOR:   result = rs_data[0] ^ rs_data[1];
            // MUL never issues here
            default:            result = '0;
        endcase
    end

    // Writes to register 0 dropped
    assign commit.valid = issue && (inst.rd != '0);
    assign commit.phys_addr = inst.rd;
    assign commit.data = result;

endmodule

//--- design/mul_unit.sv
`include "rf_defs.svh"

module mul_unit (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      issue,
    input  rf_types_pkg::phys_addr_t  rd,
    input  rf_types_pkg::data_t       rs_data [`RF_READ_PORTS],
    output rf_pipe_pkg::commit_t      commit
);
    // Operand stage plus product and output stages
    localparam int PIPE_DEPTH = `RF_MUL_LATENCY - 1;

    logic                     op_valid;
    rf_types_pkg::phys_addr_t op_rd;
    rf_types_pkg::data_t      op_a;
    rf_types_pkg::data_t      op_b;
    logic                     pipe_valid [PIPE_DEPTH];
    rf_types_pkg::phys_addr_t pipe_rd [PIPE_DEPTH];
    rf_types_pkg::data_t      pipe_data [PIPE_DEPTH];

    //////////////////////////////////////////////////////////////////////
    // Valid chain
    always_ff @(posedge clk) begin
        if (reset) begin
            op_valid <= 1'b0;
            for (int k = 0; k < PIPE_DEPTH; k++) begin
                pipe_valid[k] <= 1'b0;
            end
        end else begin
            // rd of zero gives no commit
            op_valid <= issue && (rd != '0);
            pipe_valid[0] <= op_valid;
            for (int k = 1; k < PIPE_DEPTH; k++) begin
                pipe_valid[k] <= pipe_valid[k-1];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Data path
    always_ff @(posedge clk) begin
        op_rd <= rd;
        op_a <= rs_data[0];
        op_b <= rs_data[1];
        // Low 32 bits of the product only
        pipe_rd[0] <= op_rd;
        pipe_data[0] <= op_a * op_b;
        for (int k = 1; k < PIPE_DEPTH; k++) begin
            pipe_rd[k] <= pipe_rd[k-1];
            pipe_data[k] <= pipe_data[k-1];
        end
    end

    assign commit.valid = pipe_valid[PIPE_DEPTH-1];
    assign commit.phys_addr = pipe_rd[PIPE_DEPTH-1];
    assign commit.data = pipe_data[PIPE_DEPTH-1];

endmodule

//--- design/rf_issue_top.sv
`include "rf_defs.svh"

module rf_issue_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  inst_valid,
    input  rf_pipe_pkg::inst_t    inst,
    output logic                  ready,
    output logic                  stall,
    output rf_pipe_pkg::commit_t  commit_alu,
    output rf_pipe_pkg::commit_t  commit_mul
);
    logic                     init_done;
    logic                     rs_inuse [`RF_READ_PORTS];
    logic                     rd_inuse;
    logic                     issue_alu;
    logic                     issue_mul;
    logic                     set_inuse;
    rf_types_pkg::phys_addr_t rs_addr [`RF_READ_PORTS];
    rf_types_pkg::phys_addr_t rd_addr;
    rf_types_pkg::wb_group_t  rs_group [`RF_READ_PORTS];
    rf_types_pkg::data_t      rs_data [`RF_READ_PORTS];

    //////////////////////////////////////////////////////////////////////
    // Issue and register file
    // Group of rd stays inside issue control for the group table
    issue_ctrl u_issue_ctrl (
        .clk(clk), .reset(reset), .inst_valid(inst_valid), .inst(inst),
        .init_done(init_done), .rs_inuse(rs_inuse), .rd_inuse(rd_inuse),
        .ready(ready), .stall(stall), .issue_alu(issue_alu), .issue_mul(issue_mul),
        .rs_addr(rs_addr), .rd_addr(rd_addr), .rs_group(rs_group),
        .rd_group(), .set_inuse(set_inuse)
    );

    register_file u_register_file (
        .clk(clk), .reset(reset), .rs_addr(rs_addr), .rs_group(rs_group),
        .rd_addr(rd_addr), .set_inuse(set_inuse), .commit_alu(commit_alu),
        .commit_mul(commit_mul), .rs_data(rs_data), .rs_inuse(rs_inuse),
        .rd_inuse(rd_inuse), .init_done(init_done)
    );

    //////////////////////////////////////////////////////////////////////
    // Execution units
    alu_unit u_alu_unit (
        .issue(issue_alu), .inst(inst), .rs_data(rs_data), .commit(commit_alu)
    );

    mul_unit u_mul_unit (
        .clk(clk), .reset(reset), .issue(issue_mul), .rd(inst.rd),
        .rs_data(rs_data), .commit(commit_mul)
    );

endmodule

//--- dv/rf_issue_checker.sv
`include "rf_defs.svh"

module rf_issue_checker (
    input logic                 clk,
    input logic                 reset,
    input logic                 ready,
    input logic                 stall,
    input logic                 init_done,
    input logic                 issue_alu,
    input logic                 issue_mul,
    input rf_pipe_pkg::inst_t   inst,
    input rf_pipe_pkg::commit_t commit_alu,
    input rf_pipe_pkg::commit_t commit_mul
);
    timeunit 1ns;
    timeprecision 100ps;

    // Read back by the testbench at the end of the run
    int fail_count = 0;

    //////////////////////////////////////////////////////////////////////
    // Commits

    // Register 0 is never written
    a_alu_not_r0: assert property (@(posedge clk) disable iff (reset)
        commit_alu.valid |-> commit_alu.phys_addr != '0)
        else begin $error("ALU commit to register 0"); fail_count++; end

    a_mul_not_r0: assert property (@(posedge clk) disable iff (reset)
        commit_mul.valid |-> commit_mul.phys_addr != '0)
        else begin $error("MUL commit to register 0"); fail_count++; end

    // Every MUL commit traces back to an issue exactly the latency earlier
    a_mul_from_issue: assert property (@(posedge clk) disable iff (reset)
        commit_mul.valid |-> $past(issue_mul, `RF_MUL_LATENCY)
            && $past(inst.rd, `RF_MUL_LATENCY) == commit_mul.phys_addr)
        else begin $error("MUL commit without matching issue"); fail_count++; end

    // And every MUL with a real rd does commit
    a_mul_commits: assert property (@(posedge clk) disable iff (reset)
        $past(issue_mul, `RF_MUL_LATENCY) && $past(inst.rd, `RF_MUL_LATENCY) != '0
            |-> commit_mul.valid)
        else begin $error("MUL issue lost its commit"); fail_count++; end

    //////////////////////////////////////////////////////////////////////
    // Ready, stall and sweep

    a_ready_fall: assert property (@(posedge clk)
        $fell(ready) |-> $past(reset))
        else begin $error("ready fell outside reset"); fail_count++; end

    // Not before the in-use sweep is done
    a_ready_after_sweep: assert property (@(posedge clk) disable iff (reset)
        $rose(ready) |-> $past(init_done))
        else begin $error("ready rose before init_done"); fail_count++; end

    a_no_issue_on_stall: assert property (@(posedge clk) disable iff (reset)
        stall |-> !issue_alu && !issue_mul)
        else begin $error("issue while stalled"); fail_count++; end

endmodule

//--- dv/rf_issue_tb.sv
`include "rf_defs.svh"

module rf_issue_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 3;
    localparam int NUM_REGS = `RF_NUM_PHYS_REGS;
    localparam int MUL_LAT = `RF_MUL_LATENCY;
    // Upper bound on instructions over all tests, each at most a MUL wait long
    localparam int MAX_INSTS = 40;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_REGS + MAX_INSTS * (MUL_LAT + 1) + 100;

    // Expected MUL commit, in issue order
    typedef struct packed {
        rf_types_pkg::phys_addr_t rd;
        rf_types_pkg::data_t      data;
        logic [31:0]              cycle;
    } mul_expect_t;

    logic                 clk;
    logic                 reset;
    logic                 inst_valid;
    rf_pipe_pkg::inst_t   inst;
    logic                 ready;
    logic                 stall;
    rf_pipe_pkg::commit_t commit_alu;
    rf_pipe_pkg::commit_t commit_mul;

    rf_types_pkg::data_t ref_regs [NUM_REGS];
    mul_expect_t         mul_pending [$];
    int                  seed = 32'hee9f;
    int                  errors = 0;
    int                  tests_failed = 0;
    int                  test_start;
    int                  stall_cycles = 0;
    logic [31:0]         cycle_count = '0;
    logic [31:0]         last_issue_cycle = '0;

    rf_issue_top u_rf_issue_top (
        .clk(clk), .reset(reset), .inst_valid(inst_valid), .inst(inst),
        .ready(ready), .stall(stall), .commit_alu(commit_alu), .commit_mul(commit_mul)
    );

    bind rf_issue_top rf_issue_checker u_rf_issue_checker (
        .clk(clk), .reset(reset), .ready(ready), .stall(stall), .init_done(init_done),
        .issue_alu(issue_alu), .issue_mul(issue_mul), .inst(inst),
        .commit_alu(commit_alu), .commit_mul(commit_mul)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle_count <= cycle_count + 1;

    //////////////////////////////////////////////////////////////////////
    // Reference model

    function automatic rf_types_pkg::data_t read_ref(rf_types_pkg::phys_addr_t addr);
        return (addr == '0) ? '0 : ref_regs[addr];
    endfunction

    // Result from the opcode rules, sources read from the model
    function automatic rf_types_pkg::data_t expect_result(rf_pipe_pkg::inst_t in);
        rf_types_pkg::data_t a;
        rf_types_pkg::data_t b;
        logic [63:0]         product;
        a = read_ref(in.rs1);
        b = read_ref(in.rs2);
        product = {32'h0, a} * {32'h0, b};
        case (in.op)
            rf_pipe_pkg::LOADI: return {16'h0000, in.imm};
            rf_pipe_pkg::ADD:   return a + b;
            rf_pipe_pkg::XOR:   return a ^ b;
            default:            return product[31:0];
        endcase
    endfunction

    function automatic int total_failures();
        return errors + u_rf_issue_top.u_rf_issue_checker.fail_count;
    endfunction

    task automatic flag_error(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        errors++;
    endtask

    // Mid-cycle, all DUT outputs settled
    always @(negedge clk) begin : monitor
        rf_types_pkg::data_t exp_data;
        mul_expect_t         done;
        if (!reset && inst_valid && ready && !stall) begin
            exp_data = expect_result(inst);
            last_issue_cycle = cycle_count;
            if (inst.op == rf_pipe_pkg::MUL) begin
                if (inst.rd != '0) begin
                    mul_pending.push_back('{rd: inst.rd, data: exp_data, cycle: cycle_count});
                end
            end else if (inst.rd == '0) begin
                if (commit_alu.valid) begin
                    flag_error("ALU commit for an instruction with rd 0");
                end
            end else begin
                if (!commit_alu.valid || commit_alu.phys_addr != inst.rd
                        || commit_alu.data != exp_data) begin
                    flag_error($sformatf("ALU r%0d expected %h, got valid %b r%0d %h",
                        inst.rd, exp_data, commit_alu.valid, commit_alu.phys_addr,
                        commit_alu.data));
                end
                ref_regs[inst.rd] = exp_data;
            end
        end else if (commit_alu.valid) begin
            flag_error("ALU commit without an issue");
        end
        // Group 1 commits in issue order
        if (commit_mul.valid) begin
            if (mul_pending.size() == 0) begin
                flag_error("MUL commit with no MUL pending");
            end else begin
                done = mul_pending.pop_front();
                if (commit_mul.phys_addr != done.rd || commit_mul.data != done.data
                        || cycle_count - done.cycle != MUL_LAT) begin
                    flag_error($sformatf("MUL r%0d expected %h after %0d, got r%0d %h after %0d",
                        done.rd, done.data, MUL_LAT, commit_mul.phys_addr, commit_mul.data,
                        cycle_count - done.cycle));
                end
                ref_regs[done.rd] = done.data;
            end
        end
        if (stall) begin
            stall_cycles++;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers

    function automatic rf_pipe_pkg::inst_t make_inst(rf_pipe_pkg::op_t op, int rd, int rs1,
            int rs2, rf_types_pkg::imm_t imm);
        rf_pipe_pkg::inst_t in;
        in.op = op;
        in.rd = rf_types_pkg::phys_addr_t'(rd);
        in.rs1 = rf_types_pkg::phys_addr_t'(rs1);
        in.rs2 = rf_types_pkg::phys_addr_t'(rs2);
        in.imm = imm;
        return in;
    endfunction

    // Hold the instruction until it issues, then release 1 ns after the edge
    task automatic wait_issue();
        do begin
            @(negedge clk);
        end while (!(ready && !stall));
        @(posedge clk);
        #1;
        inst_valid = 1'b0;
    endtask

    task automatic send(input rf_pipe_pkg::inst_t in);
        inst_valid = 1'b1;
        inst = in;
        wait_issue();
    endtask

    task automatic drain_mul();
        while (mul_pending.size() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic finish_test(input string name);
        if (total_failures() == test_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed with %0d errors", name, total_failures() - test_start);
            tests_failed++;
        end
        test_start = total_failures();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    initial begin : stimulus
        logic [31:0] rnd;
        logic [31:0] mul_cycle [3];
        int          ready_cycles;
        int          stall_start;
        int          early_commits;
        for (int r = 0; r < NUM_REGS; r++) begin
            ref_regs[r] = '0;
        end
        reset = 1'b1;
        inst_valid = 1'b0;
        inst = '0;
        test_start = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;

        // LOADI held from reset release on, must wait for the sweep
        reset = 1'b0;
        rnd = $random(seed);
        inst_valid = 1'b1;
        inst = make_inst(rf_pipe_pkg::LOADI, 1, 0, 0, rnd[15:0]);
        ready_cycles = 0;
        early_commits = 0;
        while (ready !== 1'b1 && ready_cycles < 2 * NUM_REGS) begin
            // Held LOADI must not reach the ALU yet
            if (commit_alu.valid) begin
                early_commits++;
            end
            @(posedge clk);
            #1;
            ready_cycles++;
        end
        if (ready_cycles != NUM_REGS) begin
            flag_error($sformatf("ready after %0d cycles, expected %0d", ready_cycles, NUM_REGS));
        end
        if (early_commits != 0) begin
            flag_error("instruction issued before ready");
        end
        wait_issue();
        finish_test("ready after sweep");

        // Random immediates, one with the top bit set
        for (int r = 2; r < 8; r++) begin
            rnd = $random(seed);
            send(make_inst(rf_pipe_pkg::LOADI, r, 0, 0, rnd[15:0]));
        end
        send(make_inst(rf_pipe_pkg::LOADI, 8, 0, 0, 16'hffff));
        finish_test("loadi zero extension");

        // ALU chain, r0 as source, no stall allowed
        stall_start = stall_cycles;
        send(make_inst(rf_pipe_pkg::ADD, 9, 1, 2, 16'h0));
        send(make_inst(rf_pipe_pkg::XOR, 10, 9, 3, 16'h0));
        send(make_inst(rf_pipe_pkg::ADD, 11, 0, 4, 16'h0));
        send(make_inst(rf_pipe_pkg::XOR, 12, 5, 0, 16'h0));
        send(make_inst(rf_pipe_pkg::ADD, 9, 10, 11, 16'h0));
        if (stall_cycles != stall_start) begin
            flag_error("stall during independent ALU sequence");
        end
        finish_test("add and xor");

        // Three in flight at once
        send(make_inst(rf_pipe_pkg::MUL, 13, 1, 2, 16'h0));
        mul_cycle[0] = last_issue_cycle;
        send(make_inst(rf_pipe_pkg::MUL, 14, 9, 10, 16'h0));
        mul_cycle[1] = last_issue_cycle;
        send(make_inst(rf_pipe_pkg::MUL, 15, 11, 12, 16'h0));
        mul_cycle[2] = last_issue_cycle;
        if (mul_cycle[1] != mul_cycle[0] + 1 || mul_cycle[2] != mul_cycle[1] + 1) begin
            flag_error("back-to-back MULs did not issue on consecutive cycles");
        end
        drain_mul();
        finish_test("pipelined mul");

        // Read via rs1, overwrite of rd, read via rs2
        send(make_inst(rf_pipe_pkg::MUL, 16, 13, 14, 16'h0));
        mul_cycle[0] = last_issue_cycle;
        send(make_inst(rf_pipe_pkg::ADD, 17, 16, 3, 16'h0));
        if (last_issue_cycle != mul_cycle[0] + MUL_LAT + 1) begin
            flag_error("rs1 hazard did not release in the cycle after commit");
        end
        send(make_inst(rf_pipe_pkg::MUL, 18, 17, 16, 16'h0));
        mul_cycle[1] = last_issue_cycle;
        rnd = $random(seed);
        send(make_inst(rf_pipe_pkg::LOADI, 18, 0, 0, rnd[15:0]));
        if (last_issue_cycle != mul_cycle[1] + MUL_LAT + 1) begin
            flag_error("rd hazard did not release in the cycle after commit");
        end
        send(make_inst(rf_pipe_pkg::MUL, 19, 18, 1, 16'h0));
        mul_cycle[2] = last_issue_cycle;
        send(make_inst(rf_pipe_pkg::XOR, 20, 1, 19, 16'h0));
        if (last_issue_cycle != mul_cycle[2] + MUL_LAT + 1) begin
            flag_error("rs2 hazard did not release in the cycle after commit");
        end
        drain_mul();
        finish_test("mul hazards");

        // No commit for rd 0, and r0 never goes pending
        send(make_inst(rf_pipe_pkg::ADD, 0, 1, 2, 16'h0));
        send(make_inst(rf_pipe_pkg::MUL, 0, 3, 4, 16'h0));
        mul_cycle[0] = last_issue_cycle;
        send(make_inst(rf_pipe_pkg::XOR, 21, 0, 5, 16'h0));
        if (last_issue_cycle != mul_cycle[0] + 1) begin
            flag_error("read of r0 stalled behind a MUL to r0");
        end
        repeat (MUL_LAT + 1) @(posedge clk);
        #1;
        finish_test("rd zero");

        $display("tests run: 6, tests failed: %0d, check errors: %0d, assertion failures: %0d",
            tests_failed, errors, u_rf_issue_top.u_rf_issue_checker.fail_count);
        if (tests_failed == 0 && total_failures() == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- flist.f
+incdir+common
common/rf_types_pkg.sv
common/rf_pipe_pkg.sv
design/issue_ctrl.sv
register_file/register_bank.sv
register_file/inuse_toggle_mem.sv
register_file/register_file.sv
design/alu_unit.sv
design/mul_unit.sv
design/rf_issue_top.sv
dv/rf_issue_checker.sv
dv/rf_issue_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rf_issue_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)
